/* source/tracker_cfg_pkg.sv */
package tracker_cfg_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Default sizes
    ////////////////////////////////////////////////////////////////////////////

    // Width of the signed input sample.
    localparam int def_data_width = 8;

    // Interval counter width, never narrower than the sample.
    localparam int def_count_width = 10;

    // Record memory depth is 2**def_addr_width.
    localparam int def_addr_width = 10;

endpackage : tracker_cfg_pkg

/* source/tracker_rec_pkg.sv */
package tracker_rec_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Record layout
    ////////////////////////////////////////////////////////////////////////////

    // Tag bits sit above the count field.
    localparam int tag_width = 2;

    // Counter wrapped, sample unchanged.
    localparam logic [tag_width-1:0] tag_wrap = 2'b00;
    // First record, payload is the sign-extended sample.
    localparam logic [tag_width-1:0] tag_start = 2'b01;
    localparam logic [tag_width-1:0] tag_fall = 2'b10;
    localparam logic [tag_width-1:0] tag_rise = 2'b11;

    // Full record width for a given count width.
    function automatic int rec_width_of(input int count_width);
        return count_width + tag_width;
    endfunction

endpackage : tracker_rec_pkg

/* source/event_timer.sv */
module event_timer #(
    parameter int data_width  = tracker_cfg_pkg::def_data_width,
    parameter int count_width = tracker_cfg_pkg::def_count_width
) (
    input  logic                         clk,
    input  logic                         rstb,
    input  logic signed [data_width-1:0] sample,
    input  logic                         clear_count,
    output logic                         rise,
    output logic                         fall,
    output logic                         wrap,
    output logic [count_width-1:0]       interval
);

    logic signed [data_width-1:0] prev_sample;
    logic [count_width-1:0]       count;
    logic                         count_max;

    ////////////////////////////////////////////////////////////////////////////
    // Change detection
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            prev_sample <= '0;
        end else begin
            prev_sample <= sample;
        end
    end

    // Signed compare against the last cycle.
    assign rise = (sample > prev_sample);
    assign fall = (sample < prev_sample);

    ////////////////////////////////////////////////////////////////////////////
    // Interval counter
    ////////////////////////////////////////////////////////////////////////////

    assign count_max = &count;

    // Free running, rolls over on its own when nobody clears it.
    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            count <= '0;
        end else if (clear_count) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // A change always wins, so wrap only fires on a quiet cycle.
    assign wrap = count_max && !rise && !fall;

    assign interval = count;

endmodule : event_timer

/* source/capture_ctrl.sv */
module capture_ctrl #(
    parameter int data_width  = tracker_cfg_pkg::def_data_width,
    parameter int count_width = tracker_cfg_pkg::def_count_width,
    parameter int addr_width  = tracker_cfg_pkg::def_addr_width
) (
    input  logic                         clk,
    input  logic                         rstb,
    input  logic                         trigger,
    input  logic signed [data_width-1:0] sample,
    input  logic                         rise,
    input  logic                         fall,
    input  logic                         wrap,
    input  logic [count_width-1:0]       interval,
    input  logic [addr_width-1:0]        read_addr,
    output logic                         clear_count,
    output logic                         mem_we,
    output logic [addr_width-1:0]        mem_addr,
    output logic [tracker_rec_pkg::rec_width_of(count_width)-1:0] mem_wdata,
    output logic                         busy,
    output logic                         full
);

    import tracker_rec_pkg::*;

    localparam logic [addr_width-1:0] last_addr = '1;

    typedef enum logic [1:0] {
        st_idle,
        st_capture,
        st_full
    } state_t;

    state_t                        state;
    logic [addr_width-1:0]         wr_addr;
    logic                          start_write;
    logic                          event_write;
    logic                          last_write;
    logic [tag_width-1:0]          event_tag;
    logic signed [count_width-1:0] start_payload;

    ////////////////////////////////////////////////////////////////////////////
    // Write decisions
    ////////////////////////////////////////////////////////////////////////////

    // Writes land on the same edge as the event.
    assign start_write = (state == st_idle) && trigger;
    assign event_write = (state == st_capture) && (rise || fall || wrap);
    assign last_write  = event_write && (wr_addr == last_addr);

    assign mem_we      = start_write || event_write;
    assign clear_count = mem_we;

    ////////////////////////////////////////////////////////////////////////////
    // Record assembly
    ////////////////////////////////////////////////////////////////////////////

    // Sign-extended or truncated to the count width.
    assign start_payload = count_width'(sample);

    // Change beats wrap.
    always_comb begin
        if (rise) begin
            event_tag = tag_rise;
        end else if (fall) begin
            event_tag = tag_fall;
        end else begin
            event_tag = tag_wrap;
        end
    end

    always_comb begin
        if (start_write) begin
            mem_wdata = {tag_start, start_payload};
        end else begin
            mem_wdata = {event_tag, interval};
        end
    end

    // Reader owns the port whenever nothing is written.
    assign mem_addr = mem_we ? wr_addr : read_addr;

    ////////////////////////////////////////////////////////////////////////////
    // Capture FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            state   <= st_idle;
            wr_addr <= '0;
        end else begin
            case (state)
                st_idle: begin
                    // Start record goes to address 0.
                    if (trigger) begin
                        state   <= st_capture;
                        wr_addr <= wr_addr + 1'b1;
                    end
                end
                st_capture: begin
                    if (last_write) begin
                        state <= st_full;
                    end else if (event_write) begin
                        wr_addr <= wr_addr + 1'b1;
                    end
                end
                st_full: begin
                    // Re-arm once the trigger drops.
                    if (!trigger) begin
                        state   <= st_idle;
                        wr_addr <= '0;
                    end
                end
                default: begin
                    state   <= st_idle;
                    wr_addr <= '0;
                end
            endcase
        end
    end

    assign busy = (state == st_capture);
    assign full = (state == st_full);

endmodule : capture_ctrl

/* source/sram.sv */
module sram #(
    parameter int addr_width = tracker_cfg_pkg::def_addr_width,
    parameter int data_width =
        tracker_rec_pkg::rec_width_of(tracker_cfg_pkg::def_count_width)
) (
    input  logic                  clk,
    input  logic                  we,
    input  logic [addr_width-1:0] addr,
    input  logic [data_width-1:0] wdata,
    output logic [data_width-1:0] rdata
);

    localparam int depth = 2 ** addr_width;

    logic [data_width-1:0] mem [depth];

    // Single port. Read data shows up one cycle after the address.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule : sram

/* source/trig_tracker.sv */
module trig_tracker #(
    parameter int data_width  = tracker_cfg_pkg::def_data_width,
    parameter int count_width = tracker_cfg_pkg::def_count_width,
    parameter int addr_width  = tracker_cfg_pkg::def_addr_width
) (
    input  logic                         clk,
    input  logic                         rstb,
    input  logic signed [data_width-1:0] sample,
    input  logic                         trigger,
    input  logic [addr_width-1:0]        read_addr,
    output logic [tracker_rec_pkg::rec_width_of(count_width)-1:0] read_data,
    output logic                         busy,
    output logic                         full
);

    import tracker_rec_pkg::*;

    localparam int rec_width = rec_width_of(count_width);

    logic                   rise;
    logic                   fall;
    logic                   wrap;
    logic [count_width-1:0] interval;
    logic                   clear_count;
    logic                   mem_we;
    logic [addr_width-1:0]  mem_addr;
    logic [rec_width-1:0]   mem_wdata;

    event_timer #(
        .data_width (data_width),
        .count_width(count_width)
    ) i_event_timer (
        .clk        (clk),
        .rstb       (rstb),
        .sample     (sample),
        .clear_count(clear_count),
        .rise       (rise),
        .fall       (fall),
        .wrap       (wrap),
        .interval   (interval)
    );

    capture_ctrl #(
        .data_width (data_width),
        .count_width(count_width),
        .addr_width (addr_width)
    ) i_capture_ctrl (
        .clk        (clk),
        .rstb       (rstb),
        .trigger    (trigger),
        .sample     (sample),
        .rise       (rise),
        .fall       (fall),
        .wrap       (wrap),
        .interval   (interval),
        .read_addr  (read_addr),
        .clear_count(clear_count),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .busy       (busy),
        .full       (full)
    );

    // Record store, read port goes straight out.
    sram #(
        .addr_width(addr_width),
        .data_width(rec_width)
    ) i_sram (
        .clk  (clk),
        .we   (mem_we),
        .addr (mem_addr),
        .wdata(mem_wdata),
        .rdata(read_data)
    );

endmodule : trig_tracker

/* dv/tb_trig_tracker.sv */
module tb_trig_tracker;

    import tracker_rec_pkg::*;

    localparam int data_width  = 8;
    localparam int count_width = 6;
    localparam int addr_width  = 4;
    localparam int rec_width   = count_width + tag_width;
    localparam int depth       = 2 ** addr_width;

    // Cycle budget per test. The random capture allows a wrap for every record.
    localparam int len_reset  = 3;
    localparam int len_idle   = 8;
    localparam int len_start  = 3;
    localparam int len_seq    = 21;
    localparam int len_hold   = 151;
    localparam int len_fill   = 40;
    localparam int len_random = depth * 64 + depth + 4;
    localparam int max_cycles = 2 * (len_reset + len_idle + len_start + len_seq
                                     + len_hold + len_fill + len_random);

    localparam int ms_idle    = 0;
    localparam int ms_capture = 1;
    localparam int ms_full    = 2;

    localparam logic [count_width-1:0] max_interval = '1;
    localparam logic [addr_width-1:0]  last_addr    = '1;

    logic                         clk;
    logic                         rstb;
    logic signed [data_width-1:0] sample;
    logic                         trigger;
    logic [addr_width-1:0]        read_addr;
    logic [rec_width-1:0]         read_data;
    logic                         busy;
    logic                         full;

    // Reference model state.
    int                           m_state;
    logic signed [data_width-1:0] m_prev;
    logic [count_width-1:0]       m_interval;
    logic [addr_width-1:0]        m_addr;
    logic [rec_width-1:0]         exp_mem [depth];

    int                           value_errors = 0;
    int                           other_errors = 0;
    int                           cycles = 0;
    logic [31:0]                  rnd;

    trig_tracker #(
        .data_width (data_width),
        .count_width(count_width),
        .addr_width (addr_width)
    ) i_dut (
        .clk      (clk),
        .rstb     (rstb),
        .sample   (sample),
        .trigger  (trigger),
        .read_addr(read_addr),
        .read_data(read_data),
        .busy     (busy),
        .full     (full)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk or negedge rstb) begin : model_step
        int                   ext;
        logic                 rise_now;
        logic                 fall_now;
        logic [tag_width-1:0] tag;
        if (!rstb) begin
            m_state    = ms_idle;
            m_prev     = '0;
            m_interval = '0;
            m_addr     = '0;
        end else begin
            rise_now = (sample > m_prev);
            fall_now = (sample < m_prev);
            case (m_state)
                ms_idle: begin
                    if (trigger) begin
                        ext        = int'(sample);
                        exp_mem[0] = {tag_start, ext[count_width-1:0]};
                        m_addr     = 4'd1;
                        m_interval = '0;
                        m_state    = ms_capture;
                    end
                end
                ms_capture: begin
                    if (rise_now || fall_now || m_interval == max_interval) begin
                        // Change first, wrap only on a quiet cycle.
                        tag = rise_now ? tag_rise : (fall_now ? tag_fall : tag_wrap);
                        exp_mem[m_addr] = {tag, m_interval};
                        m_interval      = '0;
                        if (m_addr == last_addr) begin
                            m_state = ms_full;
                        end else begin
                            m_addr = m_addr + 1'b1;
                        end
                    end else begin
                        m_interval = m_interval + 1'b1;
                    end
                end
                default: begin
                    if (!trigger) begin
                        m_state = ms_idle;
                    end
                end
            endcase
            m_prev = sample;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic void check_flags(input logic exp_busy, input logic exp_full);
        assert (busy === exp_busy) else begin
            $display("error: time %0t busy expected %b actual %b", $time, exp_busy, busy);
            value_errors++;
        end
        assert (full === exp_full) else begin
            $display("error: time %0t full expected %b actual %b", $time, exp_full, full);
            value_errors++;
        end
    endfunction

    // Flags must track the model on every cycle.
    always @(negedge clk) begin
        if (rstb) begin
            check_flags(m_state == ms_capture, m_state == ms_full);
        end
    end

    task automatic wait_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic hold_value(input logic signed [data_width-1:0] value, input int edges);
        sample = value;
        repeat (edges) wait_cycle();
    endtask

    task automatic read_word(input logic [addr_width-1:0] addr,
                             input logic [rec_width-1:0] expected);
        assert (busy === 1'b0) else begin
            $display("memory read at address %0d issued while a capture was running", addr);
            other_errors++;
        end
        read_addr = addr;
        wait_cycle();
        assert (read_data === expected) else begin
            $display("error: time %0t read_data[%0d] expected %h actual %h",
                     $time, addr, expected, read_data);
            value_errors++;
        end
    endtask

    task automatic read_all();
        logic [addr_width-1:0] addr;
        for (int a = 0; a < depth; a++) begin
            addr = addr_width'(a);
            read_word(addr, exp_mem[addr]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic idle_no_capture();
        check_flags(1'b0, 1'b0);
        hold_value(8'sd3, 1);
        hold_value(-8'sd7, 2);
        hold_value(8'sd20, 2);
        hold_value(8'sd0, 1);
        check_flags(1'b0, 1'b0);
    endtask

    task automatic start_negative();
        sample  = -8'sd5;
        trigger = 1'b1;
        wait_cycle();
        check_flags(1'b1, 1'b0);
        repeat (2) wait_cycle();
    endtask

    // Hold lengths of 1 give back-to-back change records.
    task automatic change_sequence();
        hold_value(8'sd10, 2);
        hold_value(8'sd3, 1);
        hold_value(8'sd7, 1);
        hold_value(-8'sd20, 4);
        hold_value(-8'sd19, 1);
        hold_value(8'sd100, 5);
        hold_value(-8'sd128, 1);
        hold_value(8'sd127, 3);
        hold_value(8'sd0, 1);
        hold_value(8'sd1, 2);
        check_flags(1'b1, 1'b0);
    endtask

    task automatic long_hold_wraps();
        hold_value(8'sd42, 150);
        hold_value(8'sd7, 1);
        check_flags(1'b1, 1'b0);
    endtask

    task automatic fill_and_rearm();
        hold_value(-8'sd60, 1);
        check_flags(1'b0, 1'b1);
        hold_value(8'sd5, 2);
        hold_value(8'sd90, 3);
        check_flags(1'b0, 1'b1);
        read_all();
        // Spot checks worked out by hand from the stimulus above.
        read_word(4'd0, {tag_start, 6'h3b});
        read_word(4'd11, {tag_rise, 6'd1});
        read_word(4'd12, {tag_wrap, 6'd63});
        read_word(4'd13, {tag_wrap, 6'd63});
        read_word(4'd14, {tag_fall, 6'd21});
        read_word(4'd15, {tag_fall, 6'd0});
        trigger = 1'b0;
        wait_cycle();
        check_flags(1'b0, 1'b0);
        wait_cycle();
    endtask

    task automatic random_capture();
        rnd     = next_random(rnd);
        sample  = rnd[7:0];
        trigger = 1'b1;
        wait_cycle();
        while (full !== 1'b1) begin
            rnd = next_random(rnd);
            if (rnd[8]) begin
                sample = rnd[7:0];
            end
            wait_cycle();
        end
        check_flags(1'b0, 1'b1);
        read_all();
        trigger = 1'b0;
        wait_cycle();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Run control
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("errors: %0d value, %0d other", value_errors, other_errors + 1);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        rstb      = 1'b0;
        sample    = '0;
        trigger   = 1'b0;
        read_addr = '0;
        rnd       = 32'h8211;
        repeat (3) @(posedge clk);
        #5;
        rstb = 1'b1;

        idle_no_capture();
        start_negative();
        change_sequence();
        long_hold_wraps();
        fill_and_rearm();
        random_capture();

        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : tb_trig_tracker

/* trig_tracker.f */
source/tracker_cfg_pkg.sv
source/tracker_rec_pkg.sv
source/event_timer.sv
source/capture_ctrl.sv
source/sram.sv
source/trig_tracker.sv
dv/tb_trig_tracker.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --assert --top-module tb_trig_tracker -f trig_tracker.f \
    -o sim_tb > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -q '\*\* FAIL \*\*' sim.log && { echo "simulation failed"; exit 1; }
grep -q '\*\* PASS \*\*' sim.log && exit 0
echo "simulation ended without a result"
exit 1
